// ==== mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    localparam int word_width = 32;

    // major opcode field, only the two memory classes are named
    typedef logic [6:0] opcode_t;

    localparam opcode_t op_load  = 7'b0000011;
    localparam opcode_t op_store = 7'b0100011;

    // funct3 width select
    localparam logic [2:0] f3_byte   = 3'b000;
    localparam logic [2:0] f3_half   = 3'b001;
    localparam logic [2:0] f3_word   = 3'b010;
    localparam logic [2:0] f3_byte_u = 3'b100;
    localparam logic [2:0] f3_half_u = 3'b101;

    typedef enum logic [3:0] {
        mem_op_none = 4'd0,
        lb          = 4'd1,
        lh          = 4'd2,
        lw          = 4'd3,
        lbu         = 4'd4,
        lhu         = 4'd5,
        sb          = 4'd6,
        sh          = 4'd7,
        sw          = 4'd8
    } mem_op_t;

    typedef enum logic [2:0] {
        exp_none             = 3'd0,
        exp_other            = 3'd1, // raised upstream
        exp_load_misaligned  = 3'd4,
        exp_store_misaligned = 3'd6
    } exp_code_t;

    // load format
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_t     opcode;
    } i_form_t;

    // store format, immediate split around rs1/rs2
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        opcode_t    opcode;
    } s_form_t;

    typedef union packed {
        i_form_t i_form;
        s_form_t s_form;
    } insn_u;

endpackage

`default_nettype wire

// ==== spm_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface spm_if
    import mem_pkg::*;
#(
    parameter int spm_addr_width = 6
) ();

    logic [spm_addr_width-1:0] rd_addr;    // word index
    logic [word_width-1:0]     rd_data;
    logic                      wr_en;
    logic [spm_addr_width-1:0] wr_addr;
    logic [word_width-1:0]     wr_data;
    logic [3:0]                wr_byteena;

    modport ctrl (
        output rd_addr, wr_en, wr_addr, wr_data, wr_byteena,
        input  rd_data
    );

    modport mem (
        input  rd_addr, wr_en, wr_addr, wr_data, wr_byteena,
        output rd_data
    );

endinterface

`default_nettype wire

// ==== mem_agu.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_agu
    import mem_pkg::*;
(
    input  wire logic                  en,
    input  wire insn_u                 insn,
    input  wire logic [word_width-1:0] rs1_data,
    input  wire logic [word_width-1:0] rs2_data,
    output logic [word_width-1:0]      addr,
    output mem_op_t                    mem_op,
    output logic [word_width-1:0]      store_data,
    output logic [3:0]                 byteena
);

    logic [word_width-1:0] imm_i;
    logic [word_width-1:0] imm_s;
    logic                  is_store;

    assign imm_i = {{(word_width-12){insn.i_form.imm[11]}}, insn.i_form.imm};
    assign imm_s = {{(word_width-12){insn.s_form.imm_hi[6]}},
                    insn.s_form.imm_hi, insn.s_form.imm_lo};

    assign is_store = (insn.s_form.opcode == op_store);

    // effective address
    assign addr = rs1_data + (is_store ? imm_s : imm_i);

    always_comb begin
        mem_op = mem_op_none;
        if (en) begin
            if (insn.i_form.opcode == op_load) begin
                case (insn.i_form.funct3)
                    f3_byte:   mem_op = lb;
                    f3_half:   mem_op = lh;
                    f3_word:   mem_op = lw;
                    f3_byte_u: mem_op = lbu;
                    f3_half_u: mem_op = lhu;
                    default:   mem_op = mem_op_none;
                endcase
            end else if (is_store) begin
                case (insn.s_form.funct3)
                    f3_byte: mem_op = sb;
                    f3_half: mem_op = sh;
                    f3_word: mem_op = sw;
                    default: mem_op = mem_op_none; // no unsigned stores
                endcase
            end
        end
    end

    // stores use the low lanes only
    always_comb begin
        case (mem_op)
            sb: begin
                store_data = {{(word_width-8){1'b0}}, rs2_data[7:0]};
                byteena    = 4'b0001;
            end
            sh: begin
                store_data = {{(word_width-16){1'b0}}, rs2_data[15:0]};
                byteena    = 4'b0011;
            end
            sw: begin
                store_data = rs2_data;
                byteena    = 4'b1111;
            end
            default: begin
                store_data = '0;
                byteena    = 4'b0000;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== mem_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_ctrl
    import mem_pkg::*;
#(
    parameter int spm_addr_width = 6
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  en,
    input  wire opcode_t               insn_opcode,
    input  wire exp_code_t             exp_code_in,
    input  wire logic [word_width-1:0] addr,
    input  wire mem_op_t               mem_op,
    input  wire logic [word_width-1:0] store_data,
    input  wire logic [3:0]            byteena,
    spm_if.ctrl                        spm,
    output exp_code_t                  exp_code,
    output logic [word_width-1:0]      load_data,
    output logic                       load_valid,
    output logic                       fwd
);

    logic                      misaligned;
    logic                      load_ok;
    logic                      store_ok;
    logic                      fwd_hit;
    logic [spm_addr_width-1:0] word_idx;
    logic [word_width-1:0]     raw_data;

    // store waiting for its spm write
    logic                      st_valid;
    logic [spm_addr_width-1:0] st_addr;
    logic [word_width-1:0]     st_data;
    logic [3:0]                st_byteena;

    // load in its second cycle
    mem_op_t                   ld_op;
    logic                      fwd_q;
    logic [word_width-1:0]     fwd_data;

    assign word_idx   = addr[spm_addr_width+1:2];
    assign misaligned = (addr[1:0] != 2'b00);

    // earlier exception wins over misalignment
    always_comb begin
        if (exp_code_in != exp_none)
            exp_code = exp_code_in;
        else if (misaligned && insn_opcode == op_load)
            exp_code = exp_load_misaligned;
        else if (misaligned && insn_opcode == op_store)
            exp_code = exp_store_misaligned;
        else
            exp_code = exp_none;
    end

    assign load_ok  = en && (exp_code == exp_none) && (mem_op inside {lb, lh, lw, lbu, lhu});
    assign store_ok = en && (exp_code == exp_none) && (mem_op inside {sb, sh, sw});

    // full-word store one cycle ahead at the same word
    assign fwd_hit = load_ok && st_valid && (st_byteena == 4'b1111) && (st_addr == word_idx);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            st_valid <= 1'b0;
            ld_op    <= mem_op_none;
            fwd_q    <= 1'b0;
        end else begin
            st_valid <= store_ok;
            ld_op    <= load_ok ? mem_op : mem_op_none;
            fwd_q    <= fwd_hit;
        end
    end

    always_ff @(posedge clk) begin
        st_addr    <= word_idx;
        st_data    <= store_data;
        st_byteena <= byteena;
        fwd_data   <= st_data;
    end

    assign spm.rd_addr    = word_idx;
    assign spm.wr_en      = st_valid;
    assign spm.wr_addr    = st_addr;
    assign spm.wr_data    = st_data;
    assign spm.wr_byteena = st_byteena;

    assign load_valid = (ld_op != mem_op_none);
    assign fwd        = fwd_q;

    assign raw_data = fwd_q ? fwd_data : spm.rd_data;

    always_comb begin
        case (ld_op)
            lw:      load_data = raw_data;
            lh:      load_data = {{(word_width-16){raw_data[15]}}, raw_data[15:0]};
            lhu:     load_data = {{(word_width-16){1'b0}}, raw_data[15:0]};
            lb:      load_data = {{(word_width-8){raw_data[7]}}, raw_data[7:0]};
            lbu:     load_data = {{(word_width-8){1'b0}}, raw_data[7:0]};
            default: load_data = '0; // no load in flight
        endcase
    end

endmodule

`default_nettype wire

// ==== spm.sv ====
`timescale 1ns/100ps
`default_nettype none

module spm
    import mem_pkg::*;
#(
    parameter int spm_addr_width = 6
) (
    input wire logic clk,
    input wire logic rst_n,
    spm_if.mem       bus
);

    localparam int depth = 2 ** spm_addr_width;

    logic [word_width-1:0] mem [depth];

    // contents start cleared
    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[i] = '0;
        end
    end

    // byte lane writes
    always_ff @(posedge clk) begin
        if (bus.wr_en) begin
            for (int b = 0; b < 4; b++) begin
                if (bus.wr_byteena[b])
                    mem[bus.wr_addr][8*b +: 8] <= bus.wr_data[8*b +: 8];
            end
        end
    end

    // read sees the old word on a same-edge write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            bus.rd_data <= '0;
        else
            bus.rd_data <= mem[bus.rd_addr];
    end

endmodule

`default_nettype wire

// ==== mem_stage_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_stage_top
    import mem_pkg::*;
#(
    parameter int spm_addr_width = 6
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  en,
    input  wire logic [word_width-1:0] insn,
    input  wire logic [word_width-1:0] rs1_data,
    input  wire logic [word_width-1:0] rs2_data,
    input  wire exp_code_t             exp_code_in,
    output exp_code_t                  exp_code,
    output logic [word_width-1:0]      load_data,
    output logic                       load_valid,
    output logic                       fwd
);

    insn_u                 insn_w;
    logic [word_width-1:0] addr;
    mem_op_t               mem_op;
    logic [word_width-1:0] store_data;
    logic [3:0]            byteena;

    assign insn_w = insn;

    spm_if #(
        .spm_addr_width(spm_addr_width)
    ) spm_bus ();

    mem_agu u_agu (
        .en         (en),
        .insn       (insn_w),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .addr       (addr),
        .mem_op     (mem_op),
        .store_data (store_data),
        .byteena    (byteena)
    );

    mem_ctrl #(
        .spm_addr_width(spm_addr_width)
    ) u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .en          (en),
        .insn_opcode (insn_w.i_form.opcode),
        .exp_code_in (exp_code_in),
        .addr        (addr),
        .mem_op      (mem_op),
        .store_data  (store_data),
        .byteena     (byteena),
        .spm         (spm_bus.ctrl),
        .exp_code    (exp_code),
        .load_data   (load_data),
        .load_valid  (load_valid),
        .fwd         (fwd)
    );

    spm #(
        .spm_addr_width(spm_addr_width)
    ) u_spm (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (spm_bus.mem)
    );

endmodule

`default_nettype wire

// ==== tb_mem_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_mem_stage
    import mem_pkg::*;
();

    localparam int aw      = 6;
    localparam int n_rand  = 400;
    localparam int n_fixed = 100; // upper bound on directed and idle cycles

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  en;
    logic [word_width-1:0] insn;
    logic [word_width-1:0] rs1_data;
    logic [word_width-1:0] rs2_data;
    exp_code_t             exp_code_in;
    exp_code_t             exp_code;
    logic [word_width-1:0] load_data;
    logic                  load_valid;
    logic                  fwd;

    logic [31:0] lfsr_state;
    int          exp_errors;
    int          data_errors;
    int          flag_errors;

    // model memory and the store waiting for its write
    logic [word_width-1:0] model_mem [2**aw];
    logic                  ms_valid;
    logic [aw-1:0]         ms_idx;
    logic [word_width-1:0] ms_data;
    logic [3:0]            ms_be;

    // expected load result, seen one cycle later
    logic                  want_valid;
    logic                  want_fwd;
    logic [word_width-1:0] want_data;

    always #4 clk = ~clk;

    mem_stage_top #(
        .spm_addr_width(aw)
    ) i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .en          (en),
        .insn        (insn),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .exp_code_in (exp_code_in),
        .exp_code    (exp_code),
        .load_data   (load_data),
        .load_valid  (load_valid),
        .fwd         (fwd)
    );

    // galois form, right shift
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [31:0] enc_load(input logic [2:0] f3, input logic [11:0] imm);
        return {imm, 5'd1, f3, 5'd5, op_load};
    endfunction

    function automatic logic [31:0] enc_store(input logic [2:0] f3, input logic [11:0] imm);
        return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], op_store};
    endfunction

    // width and sign by funct3
    function automatic logic [31:0] extend(input logic [2:0] f3, input logic [31:0] w);
        case (f3)
            3'd0:    return {{24{w[7]}}, w[7:0]};
            3'd1:    return {{16{w[15]}}, w[15:0]};
            3'd4:    return {24'h0, w[7:0]};
            3'd5:    return {16'h0, w[15:0]};
            default: return w;
        endcase
    endfunction

    task automatic check_exp(input exp_code_t got, input exp_code_t want);
        if (got !== want) begin
            exp_errors++;
            $display("[FAIL] exp_code got %h expected %h at %0t", got, want, $time);
        end
    endtask

    task automatic check_word(input string name, input logic [word_width-1:0] got,
                              input logic [word_width-1:0] want);
        if (got !== want) begin
            data_errors++;
            $display("[FAIL] %s got %h expected %h at %0t", name, got, want, $time);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        if (got !== want) begin
            flag_errors++;
            $display("[FAIL] %s got %h expected %h at %0t", name, got, want, $time);
        end
    endtask

    // one cycle of stimulus, with the model stepped alongside
    task automatic issue(input logic e, input logic [31:0] ins, input logic [31:0] r1,
                         input logic [31:0] r2, input exp_code_t ein);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [31:0] ea;
        exp_code_t   want_exp;
        logic        is_ld;
        logic        is_st;
        logic [aw-1:0] idx;
        logic [31:0] word;
        int          b;
        @(negedge clk);
        check_bit("load_valid", load_valid, want_valid);
        check_bit("fwd", fwd, want_fwd);
        check_word("load_data", load_data, want_data);
        en          = e;
        insn        = ins;
        rs1_data    = r1;
        rs2_data    = r2;
        exp_code_in = ein;
        #1;
        opc = ins[6:0];
        f3  = ins[14:12];
        if (opc == op_store)
            ea = r1 + sext12({ins[31:25], ins[11:7]});
        else
            ea = r1 + sext12(ins[31:20]);
        if (ein != exp_none)
            want_exp = ein;
        else if (ea[1:0] != 2'b00 && opc == op_load)
            want_exp = exp_load_misaligned;
        else if (ea[1:0] != 2'b00 && opc == op_store)
            want_exp = exp_store_misaligned;
        else
            want_exp = exp_none;
        check_exp(exp_code, want_exp);
        is_ld = e && (want_exp == exp_none) && (opc == op_load)
                && (f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5});
        is_st = e && (want_exp == exp_none) && (opc == op_store)
                && (f3 inside {3'd0, 3'd1, 3'd2});
        idx = ea[aw+1:2];
        // read happens before the pending write lands
        want_fwd   = is_ld && ms_valid && (ms_be == 4'hf) && (ms_idx == idx);
        word       = want_fwd ? ms_data : model_mem[idx];
        want_valid = is_ld;
        want_data  = is_ld ? extend(f3, word) : '0;
        if (ms_valid) begin
            for (b = 0; b < 4; b++) begin
                if (ms_be[b])
                    model_mem[ms_idx][8*b +: 8] = ms_data[8*b +: 8];
            end
        end
        ms_valid = is_st;
        if (is_st) begin
            ms_idx  = idx;
            ms_data = r2;
            ms_be   = (f3 == 3'd0) ? 4'h1 : (f3 == 3'd1) ? 4'h3 : 4'hf;
        end
    endtask

    task automatic idle();
        issue(1'b0, 32'h0, 32'h0, 32'h0, exp_none);
    endtask

    task automatic do_load(input logic [2:0] f3, input logic [31:0] base,
                           input logic [11:0] imm);
        issue(1'b1, enc_load(f3, imm), base, 32'h0, exp_none);
    endtask

    task automatic do_store(input logic [2:0] f3, input logic [31:0] base,
                            input logic [11:0] imm, input logic [31:0] data);
        issue(1'b1, enc_store(f3, imm), base, data, exp_none);
    endtask

    task automatic random_op();
        logic        e;
        logic [2:0]  sel;
        logic [11:0] imm;
        logic [31:0] ea;
        logic [31:0] r2;
        exp_code_t   ein;
        e   = (rand_bits(3) != 0);
        sel = 3'(rand_bits(3));
        imm = 12'(rand_bits(12));
        ea  = {26'h0, 4'(rand_bits(4)), 2'b00}; // 16 words, many collisions
        if (rand_bits(3) == 0)
            ea[1:0] = 2'(rand_bits(2));
        ein = (rand_bits(4) == 0) ? exp_other : exp_none;
        r2  = rand_bits(32);
        if (sel < 3'd3)
            issue(e, enc_load(3'(rand_bits(3)), imm), ea - sext12(imm), r2, ein);
        else if (sel < 3'd6)
            issue(e, enc_store({1'b0, 2'(rand_bits(2))}, imm), ea - sext12(imm), r2, ein);
        else
            issue(e, {25'(rand_bits(25)), 7'b0010011}, rand_bits(32), r2, ein);
    endtask

    initial begin
        int i;
        int n;
        lfsr_state  = 32'd72836;
        exp_errors  = 0;
        data_errors = 0;
        flag_errors = 0;
        rst_n       = 1'b0;
        en          = 1'b0;
        insn        = '0;
        rs1_data    = '0;
        rs2_data    = '0;
        exp_code_in = exp_none;
        ms_valid    = 1'b0;
        ms_idx      = '0;
        ms_data     = '0;
        ms_be       = '0;
        want_valid  = 1'b0;
        want_fwd    = 1'b0;
        want_data   = '0;
        for (i = 0; i < 2**aw; i++) begin
            model_mem[i] = '0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (4) idle(); // nothing in flight after reset

        // word store, later loads of every width
        do_store(3'd2, 32'h40, 12'h010, 32'ha5c3_8f96);
        idle();
        idle();
        do_load(3'd2, 32'h60, 12'hff0);
        do_load(3'd0, 32'h50, 12'h000);
        do_load(3'd4, 32'h50, 12'h000);
        do_load(3'd1, 32'h50, 12'h000);
        do_load(3'd5, 32'h50, 12'h000);

        // partial stores keep the other lanes
        do_store(3'd0, 32'h50, 12'h000, 32'h1111_2277);
        idle();
        idle();
        do_load(3'd2, 32'h50, 12'h000);
        do_store(3'd1, 32'h50, 12'h000, 32'h3333_4455);
        idle();
        idle();
        do_load(3'd2, 32'h50, 12'h000);

        // misaligned accesses and an upstream exception
        do_store(3'd2, 32'h51, 12'h000, 32'hffff_ffff);
        do_store(3'd1, 32'h4c, 12'h006, 32'hffff_ffff);
        do_load(3'd2, 32'h52, 12'h000);
        do_load(3'd0, 32'h50, 12'h003);
        issue(1'b1, enc_store(3'd2, 12'h000), 32'h50, 32'hdead_0000, exp_other);
        issue(1'b1, enc_load(3'd2, 12'h000), 32'h50, 32'h0, exp_other);
        idle();
        do_load(3'd2, 32'h50, 12'h000);

        // back to back at the same word
        do_store(3'd2, 32'h80, 12'h000, 32'hdead_beef);
        do_load(3'd2, 32'h80, 12'h000);
        do_store(3'd0, 32'h80, 12'h000, 32'h0000_0012);
        do_load(3'd2, 32'h80, 12'h000);
        do_store(3'd1, 32'h7c, 12'h004, 32'h0000_abcd);
        do_load(3'd4, 32'h80, 12'h000);
        idle();
        do_load(3'd2, 32'h80, 12'h000);
        idle();

        for (n = 0; n < n_rand; n++) begin
            random_op();
        end
        idle();
        idle();

        $display("error counts: exp_code %0d, load_data %0d, flags %0d",
                 exp_errors, data_errors, flag_errors);
        if (exp_errors + data_errors + flag_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // every transaction takes one 8 ns cycle
    initial begin
        #((n_rand + n_fixed) * 8 + 400);
        $display("watchdog expired before the test sequence finished");
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
mem_pkg.sv
spm_if.sv
mem_agu.sv
mem_ctrl.sv
spm.sv
mem_stage_top.sv
tb_mem_stage.sv

// ==== run_sim.sh ====
#!/bin/bash
# build and run the memory stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_mem_stage -f verilog.f \
    -o tb_mem_stage > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/tb_mem_stage > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see sim.log"
    exit 1
fi

if grep -q "tests failed" sim.log; then
    echo "FAIL, see sim.log"
    exit 1
fi
echo "PASS"
exit 0
